// File: rtl/board_pkg.sv
/* Shared widths, register map and stream types for the Ethernet test build.
   Register addresses are byte addresses; only aligned 32-bit words are mapped */
`default_nettype none

package board_pkg;

	// Meaningful widths
	typedef logic [7:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [10:0] frame_len_t;
	typedef logic [15:0] frame_cnt_t;

	// One GMII transmit byte
	typedef struct packed {
		logic [7:0] txd;
		logic tx_en;
		logic tx_er;
	} gmii_tx_t;

	// One RGMII transmit beat, low nibble on the rising edge
	typedef struct packed {
		logic [3:0] txd_rise;
		logic [3:0] txd_fall;
		logic ctl_rise;
		logic ctl_fall;
	} rgmii_tx_t;

	// AXI4-Lite master to slave
	typedef struct packed {
		axi_addr_t awaddr;
		logic awvalid;
		axi_data_t wdata;
		logic [3:0] wstrb;
		logic wvalid;
		logic bready;
		axi_addr_t araddr;
		logic arvalid;
		logic rready;
	} axil_req_t;

	// AXI4-Lite slave to master
	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		axi_data_t rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

	localparam axi_data_t BOARD_ID = 32'h4d42_0001;

	// Register map
	localparam axi_addr_t REG_ID = 8'h00;
	localparam axi_addr_t REG_CTRL = 8'h04;
	localparam axi_addr_t REG_LEN = 8'h08;
	localparam axi_addr_t REG_SEED = 8'h0C;
	localparam axi_addr_t REG_COUNT = 8'h10;
	localparam axi_addr_t REG_LED = 8'h14;

	// REG_CTRL bit positions
	localparam int CTRL_CONT_BIT = 0;
	localparam int CTRL_START_BIT = 1;
	localparam int CTRL_VCXO_BIT = 4;
	localparam int CTRL_LED_BIT = 5;

	localparam frame_len_t FRAME_LEN_DEFAULT = 11'd46;

	// Frame layout
	localparam int PREAMBLE_LEN = 7;
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE = 8'hD5;
	localparam int IFG_LEN = 12;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: rtl/ctrl_regs.sv
/* AXI4-Lite register block, one write and one read outstanding at a time.
   Unmapped or read-only targets answer SLVERR; write strobes apply per byte */
`default_nettype none
`timescale 1ns/100ps

module ctrl_regs (
	input logic tx_clk,
	input logic rst,
	input board_pkg::axil_req_t axil_req,
	output board_pkg::axil_rsp_t axil_rsp,
	input logic frame_done,
	output logic continuous,
	output logic start_pulse,
	output logic vcxo_off,
	output logic led_override,
	output logic [7:0] led_value,
	output board_pkg::frame_len_t frame_len,
	output logic [7:0] seed,
	output board_pkg::frame_cnt_t frame_count
);
	import board_pkg::*;

	// Write address and data are captured on their own
	axi_addr_t wr_addr;
	axi_data_t wr_data;
	logic [3:0] wr_strb;
	logic aw_held;
	logic w_held;

	// Response side
	logic awready;
	logic wready;
	logic bvalid;
	logic [1:0] bresp;
	logic arready;
	logic rvalid;
	axi_data_t rdata;
	logic [1:0] rresp;

	logic aw_take;
	logic w_take;
	logic ar_take;
	logic do_write;
	logic aw_held_n;
	logic w_held_n;
	logic bvalid_n;
	logic rvalid_n;
	logic wr_ok;
	axi_data_t wr_old;
	axi_data_t wr_word;
	axi_data_t rd_word;

	function automatic logic reg_mapped(input axi_addr_t addr);
		return addr inside {REG_ID, REG_CTRL, REG_LEN, REG_SEED, REG_COUNT, REG_LED};
	endfunction

	// Read view of the register file, start always reads 0
	function automatic axi_data_t reg_read(input axi_addr_t addr);
		axi_data_t val;
		val = '0;
		case (addr)
			REG_ID: val = BOARD_ID;
			REG_CTRL: begin
				val[CTRL_CONT_BIT] = continuous;
				val[CTRL_VCXO_BIT] = vcxo_off;
				val[CTRL_LED_BIT] = led_override;
			end
			REG_LEN: val[$bits(frame_len_t)-1:0] = frame_len;
			REG_SEED: val[7:0] = seed;
			REG_COUNT: val[$bits(frame_cnt_t)-1:0] = frame_count;
			REG_LED: val[7:0] = led_value;
			default: val = '0;
		endcase
		return val;
	endfunction

	assign aw_take = axil_req.awvalid && awready;
	assign w_take = axil_req.wvalid && wready;
	assign ar_take = axil_req.arvalid && arready;
	// Write fires once both halves are held
	assign do_write = aw_held && w_held;
	assign aw_held_n = (aw_held || aw_take) && !do_write;
	assign w_held_n = (w_held || w_take) && !do_write;
	assign bvalid_n = do_write || (bvalid && !axil_req.bready);
	assign rvalid_n = ar_take || (rvalid && !axil_req.rready);
	// ID and COUNT reject writes
	assign wr_ok = reg_mapped(wr_addr) && (wr_addr != REG_ID) && (wr_addr != REG_COUNT);

	always_comb begin
		rd_word = reg_mapped(axil_req.araddr) ? reg_read(axil_req.araddr) : '0;
		wr_old = reg_read(wr_addr);
		// Merge strobed bytes over the current value
		for (int i = 0; i < 4; i++) begin
			wr_word[8*i +: 8] = wr_strb[i] ? wr_data[8*i +: 8] : wr_old[8*i +: 8];
		end
	end

	// Handshake state, readies registered so they are low out of reset
	always_ff @(posedge tx_clk) begin
		if (rst) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			aw_held <= aw_held_n;
			w_held <= w_held_n;
			awready <= !aw_held_n && !bvalid_n;
			wready <= !w_held_n && !bvalid_n;
			bvalid <= bvalid_n;
			arready <= !rvalid_n;
			rvalid <= rvalid_n;
		end
	end

	// Captured payloads and response codes
	always_ff @(posedge tx_clk) begin
		if (aw_take) begin
			wr_addr <= axil_req.awaddr;
		end
		if (w_take) begin
			wr_data <= axil_req.wdata;
			wr_strb <= axil_req.wstrb;
		end
		if (do_write) begin
			bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
		end
		if (ar_take) begin
			rdata <= rd_word;
			rresp <= reg_mapped(axil_req.araddr) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// Configuration registers and frame counter
	always_ff @(posedge tx_clk) begin
		if (rst) begin
			continuous <= 1'b0;
			start_pulse <= 1'b0;
			vcxo_off <= 1'b0;
			led_override <= 1'b0;
			led_value <= '0;
			frame_len <= FRAME_LEN_DEFAULT;
			seed <= '0;
			frame_count <= '0;
		end else begin
			start_pulse <= 1'b0;
			// Wraps at full scale
			if (frame_done)
				frame_count <= frame_count + 1'b1;
			if (do_write && wr_ok) begin
				case (wr_addr)
					REG_CTRL: begin
						continuous <= wr_word[CTRL_CONT_BIT];
						start_pulse <= wr_word[CTRL_START_BIT];
						vcxo_off <= wr_word[CTRL_VCXO_BIT];
						led_override <= wr_word[CTRL_LED_BIT];
					end
					REG_LEN: frame_len <= wr_word[$bits(frame_len_t)-1:0];
					REG_SEED: seed <= wr_word[7:0];
					REG_LED: led_value <= wr_word[7:0];
					default: ;
				endcase
			end
		end
	end

	assign axil_rsp = '{
		awready: awready,
		wready: wready,
		bvalid: bvalid,
		bresp: bresp,
		arready: arready,
		rvalid: rvalid,
		rdata: rdata,
		rresp: rresp
	};

endmodule

`default_nettype wire

// File: rtl/test_frame_gen.sv
/* GMII test frame source without CRC; tx_er is held at 0.
   Length and seed are sampled at frame start, a zero length sends no payload */
`default_nettype none
`timescale 1ns/100ps

module test_frame_gen (
	input logic tx_clk,
	input logic rst,
	input logic start_pulse,
	input logic continuous,
	input board_pkg::frame_len_t frame_len,
	input logic [7:0] seed,
	output board_pkg::gmii_tx_t gmii,
	output logic frame_done
);
	import board_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		PREAMBLE,
		SFD,
		PAYLOAD,
		GAP
	} state_t;

	state_t state;
	// Shared by preamble, payload and gap
	frame_len_t byte_cnt;
	frame_len_t len_q;
	logic [7:0] seed_q;
	logic start_req;

	assign start_req = start_pulse || continuous;
	// High in the last idle cycle of the gap
	assign frame_done = (state == GAP) && (byte_cnt == frame_len_t'(IFG_LEN - 1));

	// Frame parameters latched as the frame begins
	always_ff @(posedge tx_clk) begin
		if (state == IDLE && start_req) begin
			len_q <= frame_len;
			seed_q <= seed;
		end
	end

	// gmii always shows the byte of the current state
	always_ff @(posedge tx_clk) begin
		if (rst) begin
			state <= IDLE;
			byte_cnt <= '0;
			gmii <= '0;
		end else begin
			gmii.tx_er <= 1'b0;
			case (state)
				IDLE: begin
					if (start_req) begin
						state <= PREAMBLE;
						byte_cnt <= '0;
						gmii.txd <= PREAMBLE_BYTE;
						gmii.tx_en <= 1'b1;
					end
				end
				PREAMBLE: begin
					if (byte_cnt == frame_len_t'(PREAMBLE_LEN - 1)) begin
						state <= SFD;
						gmii.txd <= SFD_BYTE;
					end else begin
						byte_cnt <= byte_cnt + 1'b1;
					end
				end
				SFD: begin
					byte_cnt <= '0;
					if (len_q == '0) begin
						state <= GAP;
						gmii <= '0;
					end else begin
						// First payload byte is the seed
						state <= PAYLOAD;
						gmii.txd <= seed_q;
					end
				end
				PAYLOAD: begin
					if (byte_cnt == len_q - 1'b1) begin
						state <= GAP;
						byte_cnt <= '0;
						gmii <= '0;
					end else begin
						byte_cnt <= byte_cnt + 1'b1;
						// Counting pattern, wraps mod 256
						gmii.txd <= gmii.txd + 1'b1;
					end
				end
				GAP: begin
					if (frame_done) begin
						state <= IDLE;
						byte_cnt <= '0;
					end else begin
						byte_cnt <= byte_cnt + 1'b1;
					end
				end
				default: begin
					state <= IDLE;
					gmii <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/gmii_to_rgmii.sv
/* Registered GMII to RGMII transmit fold, one cycle of latency.
   Models the DDR output as a nibble pair; no clock forwarding or skew */
`default_nettype none
`timescale 1ns/100ps

module gmii_to_rgmii (
	input logic tx_clk,
	input logic rst,
	input board_pkg::gmii_tx_t gmii,
	output board_pkg::rgmii_tx_t rgmii
);

	logic [3:0] txd_rise;
	logic [3:0] txd_fall;
	logic ctl_rise;
	logic ctl_fall;

	// RGMII control, rising carries tx_en
	// falling carries tx_en xor tx_er
	always_ff @(posedge tx_clk) begin
		if (rst) begin
			ctl_rise <= 1'b0;
			ctl_fall <= 1'b0;
		end else begin
			ctl_rise <= gmii.tx_en;
			ctl_fall <= gmii.tx_en ^ gmii.tx_er;
		end
	end

	// Low nibble first, then high nibble
	always_ff @(posedge tx_clk) begin
		txd_rise <= gmii.txd[3:0];
		txd_fall <= gmii.txd[7:4];
	end

	assign rgmii = '{
		txd_rise: txd_rise,
		txd_fall: txd_fall,
		ctl_rise: ctl_rise,
		ctl_fall: ctl_fall
	};

endmodule

`default_nettype wire

// File: rtl/board_base.sv
/* Portable core of the test build, all on tx_clk.
   LEDs lag their source by one cycle */
`default_nettype none
`timescale 1ns/100ps

module board_base (
	input logic tx_clk,
	input logic rst,
	input board_pkg::axil_req_t axil_req,
	output board_pkg::axil_rsp_t axil_rsp,
	output board_pkg::gmii_tx_t gmii,
	output logic [7:0] leds,
	output logic vcxo_en
);
	import board_pkg::*;

	// Configuration from the register block
	logic continuous;
	logic start_pulse;
	logic vcxo_off;
	logic led_override;
	logic [7:0] led_value;
	frame_len_t frame_len;
	logic [7:0] seed;
	frame_cnt_t frame_count;
	logic frame_done;

	ctrl_regs regs_i (
		.tx_clk(tx_clk),
		.rst(rst),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.frame_done(frame_done),
		.continuous(continuous),
		.start_pulse(start_pulse),
		.vcxo_off(vcxo_off),
		.led_override(led_override),
		.led_value(led_value),
		.frame_len(frame_len),
		.seed(seed),
		.frame_count(frame_count)
	);

	test_frame_gen gen_i (
		.tx_clk(tx_clk),
		.rst(rst),
		.start_pulse(start_pulse),
		.continuous(continuous),
		.frame_len(frame_len),
		.seed(seed),
		.gmii(gmii),
		.frame_done(frame_done)
	);

	// Override value, else low byte of the frame count
	always_ff @(posedge tx_clk) begin
		if (rst)
			leds <= '0;
		else
			leds <= led_override ? led_value : frame_count[7:0];
	end

	// Oscillator runs unless software turns it off
	assign vcxo_en = ~vcxo_off;

endmodule

`default_nettype wire

// File: rtl/board_top.sv
/* Board top for simulation, no vendor clocking or I/O cells.
   RGMII transmit beats appear as nibble pairs on rgmii_tx */
`default_nettype none
`timescale 1ns/100ps

module board_top (
	input logic tx_clk,
	input logic rst,
	input board_pkg::axil_req_t axil_req,
	output board_pkg::axil_rsp_t axil_rsp,
	output board_pkg::rgmii_tx_t rgmii_tx,
	output logic [7:0] leds,
	output logic vcxo_en
);
	import board_pkg::*;

	// GMII between core and PHY stage
	gmii_tx_t gmii;

	board_base base_i (
		.tx_clk(tx_clk),
		.rst(rst),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.gmii(gmii),
		.leds(leds),
		.vcxo_en(vcxo_en)
	);

	// Stands in for the DDR output cells
	gmii_to_rgmii gmii_to_rgmii_i (
		.tx_clk(tx_clk),
		.rst(rst),
		.gmii(gmii),
		.rgmii(rgmii_tx)
	);

endmodule

`default_nettype wire

// File: tests/board_top_sva.sv
/* Bound checks on the AXI4-Lite handshake and the RGMII transmit encoding.
   fail_count lets the testbench see how many assertions fired */
`default_nettype none
`timescale 1ns/100ps

module board_top_sva (
	input logic tx_clk,
	input logic rst,
	input board_pkg::axil_req_t axil_req,
	input board_pkg::axil_rsp_t axil_rsp,
	input board_pkg::gmii_tx_t gmii,
	input board_pkg::rgmii_tx_t rgmii_tx
);
	import board_pkg::*;

	int fail_count = 0;

	// Write response held under back-pressure
	b_held: assert property (@(posedge tx_clk) disable iff (rst)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
	else begin
		$error("write response dropped or changed before bready");
		fail_count++;
	end

	// Read data held under back-pressure
	r_held: assert property (@(posedge tx_clk) disable iff (rst)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
	else begin
		$error("read data dropped or changed before rready");
		fail_count++;
	end

	// RGMII control: rise is tx_en, fall is tx_en xor tx_er, one cycle later
	ctl_rule: assert property (@(posedge tx_clk) disable iff (rst)
		rgmii_tx.ctl_rise == $past(gmii.tx_en)
		&& rgmii_tx.ctl_fall == ($past(gmii.tx_en) ^ $past(gmii.tx_er)))
	else begin
		$error("RGMII control encoding broken");
		fail_count++;
	end

	// Nothing valid in the cycle after a reset cycle
	reset_quiet: assert property (@(posedge tx_clk)
		rst |=> !axil_rsp.awready && !axil_rsp.wready && !axil_rsp.arready
		&& !axil_rsp.bvalid && !axil_rsp.rvalid && !rgmii_tx.ctl_rise && !rgmii_tx.ctl_fall)
	else begin
		$error("response or RGMII control active after reset");
		fail_count++;
	end

endmodule

bind board_top board_top_sva sva_i (
	.tx_clk(tx_clk),
	.rst(rst),
	.axil_req(axil_req),
	.axil_rsp(axil_rsp),
	.gmii(gmii),
	.rgmii_tx(rgmii_tx)
);

`default_nettype wire

// File: tests/board_top_tb.sv
/* Testbench for board_top: AXI4-Lite master tasks and an RGMII frame decoder.
   Stops at the first failed check; a watchdog bounds the run length */
`default_nettype none
`timescale 1ns/100ps

module board_top_tb;
	import board_pkg::*;

	// Watchdog budget from frame count, longest frame and AXI traffic
	localparam int LEN_MAX = 80;
	localparam int FRAMES_MAX = 6;
	localparam int XFER_MAX = 64;
	localparam int XFER_CYCLES = 24;
	localparam int WATCHDOG_CYCLES = FRAMES_MAX * (PREAMBLE_LEN + 1 + LEN_MAX + IFG_LEN + 2)
		+ XFER_MAX * XFER_CYCLES + 200;

	logic tx_clk;
	logic rst;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	rgmii_tx_t rgmii_tx;
	logic [7:0] leds;
	logic vcxo_en;

	int rnd_seed = 32'h3d00_d332;
	// Decoder state
	logic [7:0] frame_q[$];
	logic [7:0] last_frame[$];
	int frames_seen;
	int idle_run;
	logic in_frame;

	board_top board_top_i (
		.tx_clk(tx_clk),
		.rst(rst),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.rgmii_tx(rgmii_tx),
		.leds(leds),
		.vcxo_en(vcxo_en)
	);

	always #2 tx_clk = ~tx_clk;

	function automatic int rand_below(input int n);
		return int'($unsigned($random(rnd_seed)) % n);
	endfunction

	task automatic stop_run();
		$display("test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic expect_eq(input string test, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("mismatch %s: expected %0h, actual %0h", test, exp, act);
			stop_run();
		end
	endtask

	// Address and data phases start after their own delays
	task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input int aw_dly,
			input int w_dly, input int b_dly, output logic [1:0] resp);
		bit aw_done;
		bit w_done;
		int cyc;
		aw_done = 1'b0;
		w_done = 1'b0;
		cyc = 0;
		while (!(aw_done && w_done)) begin
			if (cyc == aw_dly) begin
				axil_req.awaddr <= addr;
				axil_req.awvalid <= 1'b1;
			end
			if (cyc == w_dly) begin
				axil_req.wdata <= data;
				axil_req.wstrb <= 4'hF;
				axil_req.wvalid <= 1'b1;
			end
			@(posedge tx_clk);
			cyc++;
			// Handshakes seen with pre-edge values
			if (axil_req.awvalid && axil_rsp.awready) begin
				aw_done = 1'b1;
				axil_req.awvalid <= 1'b0;
			end
			if (axil_req.wvalid && axil_rsp.wready) begin
				w_done = 1'b1;
				axil_req.wvalid <= 1'b0;
			end
		end
		// bready held low for b_dly cycles
		repeat (b_dly) @(posedge tx_clk);
		axil_req.bready <= 1'b1;
		do begin
			@(posedge tx_clk);
		end while (!axil_rsp.bvalid);
		resp = axil_rsp.bresp;
		axil_req.bready <= 1'b0;
	endtask

	task automatic axi_read(input axi_addr_t addr, input int ar_dly, input int r_dly,
			output axi_data_t data, output logic [1:0] resp);
		repeat (ar_dly) @(posedge tx_clk);
		axil_req.araddr <= addr;
		axil_req.arvalid <= 1'b1;
		do begin
			@(posedge tx_clk);
		end while (!axil_rsp.arready);
		axil_req.arvalid <= 1'b0;
		repeat (r_dly) @(posedge tx_clk);
		axil_req.rready <= 1'b1;
		do begin
			@(posedge tx_clk);
		end while (!axil_rsp.rvalid);
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		axil_req.rready <= 1'b0;
	endtask

	task automatic write_check(input string test, input axi_addr_t addr, input axi_data_t data,
			input logic [1:0] exp_resp);
		logic [1:0] resp;
		axi_write(addr, data, 0, 0, 0, resp);
		expect_eq({test, "_bresp"}, exp_resp, resp);
	endtask

	task automatic read_check(input string test, input axi_addr_t addr, input axi_data_t exp_data,
			input logic [1:0] exp_resp);
		axi_data_t data;
		logic [1:0] resp;
		axi_read(addr, 0, 0, data, resp);
		expect_eq({test, "_rresp"}, exp_resp, resp);
		expect_eq(test, exp_data, data);
	endtask

	// Preamble, delimiter, then seed counting up mod 256
	task automatic check_frame(input string test, input int len, input logic [7:0] pay_seed);
		logic [7:0] exp_byte;
		expect_eq({test, "_size"}, PREAMBLE_LEN + 1 + len, last_frame.size());
		for (int i = 0; i < PREAMBLE_LEN; i++)
			expect_eq({test, "_preamble"}, 8'h55, last_frame[i]);
		expect_eq({test, "_sfd"}, 8'hD5, last_frame[PREAMBLE_LEN]);
		exp_byte = pay_seed;
		for (int i = 0; i < len; i++) begin
			expect_eq({test, "_payload"}, exp_byte, last_frame[PREAMBLE_LEN + 1 + i]);
			exp_byte = exp_byte + 8'd1;
		end
	endtask

	task automatic wait_frames(input int n);
		while (frames_seen < n)
			@(posedge tx_clk);
	endtask

	// Idle longer than any gap in continuous mode, so the generator has stopped
	task automatic wait_idle();
		while (in_frame || idle_run < IFG_LEN + 4)
			@(posedge tx_clk);
	endtask

	// Bytes rebuilt at the falling edge, where rgmii_tx is settled
	always @(negedge tx_clk) begin
		if (rst) begin
			frame_q.delete();
			frames_seen = 0;
			idle_run = 0;
			in_frame = 1'b0;
		end else begin
			// tx_er is never set, so both halves of ctl match
			expect_eq("rgmii_ctl", rgmii_tx.ctl_rise, rgmii_tx.ctl_fall);
			if (rgmii_tx.ctl_rise) begin
				if (!in_frame && frames_seen > 0) begin
					assert (idle_run >= IFG_LEN) else begin
						$display("inter-frame gap of %0d beats is below %0d", idle_run, IFG_LEN);
						stop_run();
					end
				end
				in_frame = 1'b1;
				idle_run = 0;
				frame_q.push_back({rgmii_tx.txd_fall, rgmii_tx.txd_rise});
			end else begin
				if (in_frame) begin
					last_frame = frame_q;
					frame_q.delete();
					frames_seen++;
				end
				in_frame = 1'b0;
				idle_run++;
			end
		end
	end

	// A bound assertion failure ends the run at once
	always @(board_top_i.sva_i.fail_count) begin
		if (board_top_i.sva_i.fail_count != 0) begin
			$display("bound assertion failed, %0d so far", board_top_i.sva_i.fail_count);
			stop_run();
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge tx_clk);
		$display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		stop_run();
	end

	initial begin
		logic [1:0] resp;
		axi_data_t data;
		axi_data_t val;
		axi_addr_t addr;
		int len;
		int base;
		logic [7:0] pay_seed;
		tx_clk = 1'b0;
		rst = 1'b1;
		axil_req = '0;
		repeat (5) @(posedge tx_clk);
		rst <= 1'b0;
		@(posedge tx_clk);

		// Reset values
		read_check("reset_id", REG_ID, 32'h4d42_0001, RESP_OKAY);
		read_check("reset_len", REG_LEN, 32'd46, RESP_OKAY);
		read_check("reset_seed", REG_SEED, 32'd0, RESP_OKAY);
		read_check("reset_count", REG_COUNT, 32'd0, RESP_OKAY);
		expect_eq("reset_leds", 32'h0, leds);
		expect_eq("reset_vcxo", 32'h1, vcxo_en);

		// Single frame, start bit reads back 0
		len = 1 + rand_below(LEN_MAX);
		pay_seed = 8'(rand_below(256));
		write_check("single_len", REG_LEN, len, RESP_OKAY);
		write_check("single_seed", REG_SEED, pay_seed, RESP_OKAY);
		write_check("single_start", REG_CTRL, 32'h2, RESP_OKAY);
		wait_frames(1);
		check_frame("single_frame", len, pay_seed);
		read_check("single_ctrl", REG_CTRL, 32'h0, RESP_OKAY);
		wait_idle();
		read_check("single_count", REG_COUNT, 32'd1, RESP_OKAY);

		// Continuous stream, short frames
		len = 8 + rand_below(16);
		pay_seed = 8'(rand_below(256));
		write_check("cont_len", REG_LEN, len, RESP_OKAY);
		write_check("cont_seed", REG_SEED, pay_seed, RESP_OKAY);
		write_check("cont_go", REG_CTRL, 32'h1, RESP_OKAY);
		base = frames_seen;
		for (int k = 1; k <= 3; k++) begin
			wait_frames(base + k);
			check_frame("cont_frame", len, pay_seed);
		end
		write_check("cont_stop", REG_CTRL, 32'h0, RESP_OKAY);
		wait_idle();
		read_check("cont_count", REG_COUNT, frames_seen, RESP_OKAY);

		// LED source and oscillator enable
		write_check("led_value", REG_LED, 32'hA5, RESP_OKAY);
		write_check("led_on", REG_CTRL, 32'h20, RESP_OKAY);
		repeat (2) @(posedge tx_clk);
		expect_eq("led_override", 32'hA5, leds);
		write_check("led_off", REG_CTRL, 32'h10, RESP_OKAY);
		repeat (2) @(posedge tx_clk);
		expect_eq("led_count", frames_seen % 256, leds);
		expect_eq("vcxo_off", 32'h0, vcxo_en);
		write_check("vcxo_on", REG_CTRL, 32'h0, RESP_OKAY);
		repeat (2) @(posedge tx_clk);
		expect_eq("vcxo_on", 32'h1, vcxo_en);

		// Rejected writes change nothing, 0x28 aliases REG_LEN in its low bits
		write_check("err_id", REG_ID, 32'hFFFF_FFFF, RESP_SLVERR);
		write_check("err_count", REG_COUNT, 32'h1234, RESP_SLVERR);
		write_check("err_unmapped", 8'h28, 32'h55, RESP_SLVERR);
		read_check("err_id_kept", REG_ID, 32'h4d42_0001, RESP_OKAY);
		read_check("err_count_kept", REG_COUNT, frames_seen, RESP_OKAY);
		read_check("err_len_kept", REG_LEN, len, RESP_OKAY);
		read_check("err_led_kept", REG_LED, 32'hA5, RESP_OKAY);
		read_check("err_unmapped_rd", 8'h28, 32'h0, RESP_SLVERR);

		// Skewed phases and back-pressure on both responses
		for (int k = 0; k < 8; k++) begin
			addr = (k % 2 == 0) ? REG_LEN : REG_SEED;
			val = (k % 2 == 0) ? axi_data_t'(rand_below(2048)) : axi_data_t'(rand_below(256));
			axi_write(addr, val, rand_below(6), rand_below(6), rand_below(6), resp);
			expect_eq("skew_bresp", RESP_OKAY, resp);
			axi_read(addr, rand_below(6), rand_below(6), data, resp);
			expect_eq("skew_rresp", RESP_OKAY, resp);
			expect_eq("skew_rdata", val, data);
		end

		repeat (4) @(posedge tx_clk);
		if (board_top_i.sva_i.fail_count == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("%0d bound assertion failures", board_top_i.sva_i.fail_count);
			stop_run();
		end
	end

endmodule

`default_nettype wire

// File: compile.f
rtl/board_pkg.sv
rtl/ctrl_regs.sv
rtl/test_frame_gen.sv
rtl/gmii_to_rgmii.sv
rtl/board_base.sv
rtl/board_top.sv
tests/board_top_sva.sv
tests/board_top_tb.sv
